//--- barrierPkg.sv
package barrierPkg;

	// screen coordinate on the 640x480 raster
	typedef logic [9:0] coordT;

	// bunker number, 0 is the leftmost bunker
	typedef logic [1:0] barrierIdT;

	// block column or row inside one bunker
	typedef logic [1:0] blkIdxT;

	// zero means the block is gone, 3 is the most a block can hold
	typedef logic [1:0] healthT;

	// all bunkers share one vertical band
	localparam coordT BARR_YSTART = 10'd400;

	// one block is a square of this many pixels
	localparam coordT BARR_BLK_SZ = 10'd8;

	// a bunker is four blocks across and four blocks down
	localparam coordT BARR_WIDTH = 10'd32;
	localparam coordT BARR_HEIGHT = 10'd32;

	// left edge of each bunker, indexed by bunker number
	localparam coordT BARR_XSTART [4] = '{
		10'd80,
		10'd224,
		10'd368,
		10'd512
	};

	// hit controller states
	typedef enum logic {
		IDLE,
		CHECK
	} hitStateT;

endpackage

//--- barrierLocate.sv
`timescale 1ns/1ps

module barrierLocate (
	input barrierPkg::coordT xCoord,
	input barrierPkg::coordT yCoord,
	output barrierPkg::barrierIdT currBarrier,
	output barrierPkg::blkIdxT xVal,
	output barrierPkg::blkIdxT yVal,
	output logic inBarrier
);
	import barrierPkg::*;

	logic inBand;
	coordT shiftedX;
	coordT shiftedY;
	coordT colFull;
	coordT rowFull;

	always_comb begin
		inBand = (yCoord >= BARR_YSTART) && (yCoord < BARR_YSTART + BARR_HEIGHT);
		shiftedY = yCoord - BARR_YSTART;
		shiftedX = '0;
		currBarrier = '0;
		inBarrier = 1'b0;

		// spans are half open, so the pixel at start + width belongs to no bunker
		if (inBand) begin
			for (int i = 0; i < 4; i++) begin
				if ((xCoord >= BARR_XSTART[i]) && (xCoord < BARR_XSTART[i] + BARR_WIDTH)) begin
					currBarrier = barrierIdT'(i);
					shiftedX = xCoord - BARR_XSTART[i];
					inBarrier = 1'b1;
				end
			end
		end

		// block size is a power of two, so the divide reduces to a shift
		colFull = shiftedX / BARR_BLK_SZ;
		rowFull = shiftedY / BARR_BLK_SZ;

		if (inBarrier) begin
			xVal = colFull[1:0];
			yVal = rowFull[1:0];
		end else begin
			xVal = '0;
			yVal = '0;
		end
	end

endmodule

//--- barrierHealthRegs.sv
`timescale 1ns/1ps

module barrierHealthRegs #(
	parameter barrierPkg::healthT fullHealth = 2'd3
) (
	input logic clk,
	input logic rstN,
	input barrierPkg::barrierIdT rdBarrierA,
	input barrierPkg::blkIdxT rdColA,
	input barrierPkg::blkIdxT rdRowA,
	input barrierPkg::barrierIdT rdBarrierB,
	input barrierPkg::blkIdxT rdColB,
	input barrierPkg::blkIdxT rdRowB,
	output barrierPkg::healthT rdHealthA,
	output barrierPkg::healthT rdHealthB,
	input logic wrEn,
	input barrierPkg::barrierIdT wrBarrier,
	input barrierPkg::blkIdxT wrCol,
	input barrierPkg::blkIdxT wrRow,
	input barrierPkg::healthT wrHealth
);
	import barrierPkg::*;

	// indexed by bunker, then column, then row
	healthT healthMem [4][4][4];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			// every block comes back at full strength
			for (int b = 0; b < 4; b++) begin
				for (int c = 0; c < 4; c++) begin
					for (int r = 0; r < 4; r++) begin
						healthMem[b][c][r] <= fullHealth;
					end
				end
			end
		end else if (wrEn) begin
			healthMem[wrBarrier][wrCol][wrRow] <= wrHealth;
		end
	end

	// port A feeds the pixel path, port B the hit controller
	assign rdHealthA = healthMem[rdBarrierA][rdColA][rdRowA];
	assign rdHealthB = healthMem[rdBarrierB][rdColB][rdRowB];

endmodule

//--- barrierHitCtrl.sv
`timescale 1ns/1ps

module barrierHitCtrl (
	input logic clk,
	input logic rstN,
	input logic hitStrobe,
	input barrierPkg::coordT bulletX,
	input barrierPkg::coordT bulletY,
	output barrierPkg::barrierIdT rdBarrier,
	output barrierPkg::blkIdxT rdCol,
	output barrierPkg::blkIdxT rdRow,
	input barrierPkg::healthT rdHealth,
	output logic wrEn,
	output barrierPkg::barrierIdT wrBarrier,
	output barrierPkg::blkIdxT wrCol,
	output barrierPkg::blkIdxT wrRow,
	output barrierPkg::healthT wrHealth,
	output logic hitDone,
	output logic hitBarrier,
	output barrierPkg::barrierIdT hitId
);
	import barrierPkg::*;

	hitStateT state;
	coordT bulletXQ;
	coordT bulletYQ;
	barrierIdT locBarrier;
	blkIdxT locCol;
	blkIdxT locRow;
	logic locInside;
	logic liveHit;

	barrierLocate bulletLocate (
		.xCoord(bulletXQ),
		.yCoord(bulletYQ),
		.currBarrier(locBarrier),
		.xVal(locCol),
		.yVal(locRow),
		.inBarrier(locInside)
	);

	// a strobe seen during CHECK is dropped since CHECK always falls back to IDLE
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (hitStrobe) state <= CHECK;
				CHECK: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// hold the bullet position for the check cycle
	always_ff @(posedge clk) begin
		if ((state == IDLE) && hitStrobe) begin
			bulletXQ <= bulletX;
			bulletYQ <= bulletY;
		end
	end

	// read and write address the same block, so the write lands at the end of CHECK
	assign rdBarrier = locBarrier;
	assign rdCol = locCol;
	assign rdRow = locRow;
	assign wrBarrier = locBarrier;
	assign wrCol = locCol;
	assign wrRow = locRow;

	assign liveHit = locInside && (rdHealth != '0);
	assign wrEn = (state == CHECK) && liveHit;
	assign wrHealth = rdHealth - 2'd1;

	assign hitDone = (state == CHECK);
	assign hitBarrier = liveHit;
	assign hitId = locBarrier;

endmodule

//--- barrierPixel.sv
`timescale 1ns/1ps

module barrierPixel (
	input logic clk,
	input logic rstN,
	input barrierPkg::coordT pixX,
	input barrierPkg::coordT pixY,
	output barrierPkg::barrierIdT rdBarrier,
	output barrierPkg::blkIdxT rdCol,
	output barrierPkg::blkIdxT rdRow,
	input barrierPkg::healthT rdHealth,
	output logic pixOn,
	output barrierPkg::healthT pixHealth
);
	import barrierPkg::*;

	logic pixInside;
	logic blockLive;

	barrierLocate pixelLocate (
		.xCoord(pixX),
		.yCoord(pixY),
		.currBarrier(rdBarrier),
		.xVal(rdCol),
		.yVal(rdRow),
		.inBarrier(pixInside)
	);

	// a destroyed block is drawn as background
	assign blockLive = pixInside && (rdHealth != '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pixOn <= 1'b0;
			pixHealth <= '0;
		end else begin
			pixOn <= blockLive;
			pixHealth <= blockLive ? rdHealth : healthT'(0);
		end
	end

endmodule

//--- barrierTop.sv
`timescale 1ns/1ps

module barrierTop #(
	parameter barrierPkg::healthT fullHealth = 2'd3
) (
	input logic clk,
	input logic rstN,
	input barrierPkg::coordT pixX,
	input barrierPkg::coordT pixY,
	output logic pixOn,
	output barrierPkg::healthT pixHealth,
	input logic hitStrobe,
	input barrierPkg::coordT bulletX,
	input barrierPkg::coordT bulletY,
	output logic hitDone,
	output logic hitBarrier,
	output barrierPkg::barrierIdT hitId
);
	import barrierPkg::*;

	// pixel path read port
	barrierIdT pixRdBarrier;
	blkIdxT pixRdCol;
	blkIdxT pixRdRow;
	healthT pixRdHealth;

	// hit path read and write ports
	barrierIdT hitRdBarrier;
	blkIdxT hitRdCol;
	blkIdxT hitRdRow;
	healthT hitRdHealth;
	logic wrEn;
	barrierIdT wrBarrier;
	blkIdxT wrCol;
	blkIdxT wrRow;
	healthT wrHealth;

	barrierHealthRegs #(
		.fullHealth(fullHealth)
	) healthRegs (
		.clk(clk),
		.rstN(rstN),
		.rdBarrierA(pixRdBarrier),
		.rdColA(pixRdCol),
		.rdRowA(pixRdRow),
		.rdBarrierB(hitRdBarrier),
		.rdColB(hitRdCol),
		.rdRowB(hitRdRow),
		.rdHealthA(pixRdHealth),
		.rdHealthB(hitRdHealth),
		.wrEn(wrEn),
		.wrBarrier(wrBarrier),
		.wrCol(wrCol),
		.wrRow(wrRow),
		.wrHealth(wrHealth)
	);

	barrierHitCtrl hitCtrl (
		.clk(clk),
		.rstN(rstN),
		.hitStrobe(hitStrobe),
		.bulletX(bulletX),
		.bulletY(bulletY),
		.rdBarrier(hitRdBarrier),
		.rdCol(hitRdCol),
		.rdRow(hitRdRow),
		.rdHealth(hitRdHealth),
		.wrEn(wrEn),
		.wrBarrier(wrBarrier),
		.wrCol(wrCol),
		.wrRow(wrRow),
		.wrHealth(wrHealth),
		.hitDone(hitDone),
		.hitBarrier(hitBarrier),
		.hitId(hitId)
	);

	barrierPixel pixel (
		.clk(clk),
		.rstN(rstN),
		.pixX(pixX),
		.pixY(pixY),
		.rdBarrier(pixRdBarrier),
		.rdCol(pixRdCol),
		.rdRow(pixRdRow),
		.rdHealth(pixRdHealth),
		.pixOn(pixOn),
		.pixHealth(pixHealth)
	);

endmodule

//--- tb_barrierTop.sv
`timescale 1ns/1ps

module tb_barrierTop;
	import barrierPkg::*;

	logic clk;
	logic rstN;
	coordT pixX;
	coordT pixY;
	logic pixOn;
	healthT pixHealth;
	logic hitStrobe;
	coordT bulletX;
	coordT bulletY;
	logic hitDone;
	logic hitBarrier;
	barrierIdT hitId;

	integer fd;
	integer scanCode;
	integer passCount;
	integer failCount;
	integer testNum;
	integer argX;
	integer argY;
	integer expA;
	integer expB;
	logic abortRun;
	logic fileDone;
	logic testOk;
	logic [7:0] opChar;
	logic [1023:0] restOfLine;
	string opName;

	barrierTop #(
		.fullHealth(2'd3)
	) DUT (
		.clk(clk),
		.rstN(rstN),
		.pixX(pixX),
		.pixY(pixY),
		.pixOn(pixOn),
		.pixHealth(pixHealth),
		.hitStrobe(hitStrobe),
		.bulletX(bulletX),
		.bulletY(bulletY),
		.hitDone(hitDone),
		.hitBarrier(hitBarrier),
		.hitId(hitId)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// the pixel held during reset shows up at the outputs only if reset fails to clear them
	task automatic applyReset(input integer holdX, input integer holdY);
		@(negedge clk);
		rstN = 1'b0;
		hitStrobe = 1'b0;
		pixX = coordT'(holdX);
		pixY = coordT'(holdY);
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	endtask

	task automatic checkAfterReset(input integer x, input integer y, input integer expOn,
		input integer expHealth, output logic ok);
		ok = 1'b1;
		applyReset(x, y);
		if (pixOn !== 1'(expOn)) begin
			$display("FAILED at %0t ns: pixOn expected %0d got %0d", $time, expOn, pixOn);
			ok = 1'b0;
		end
		if (pixHealth !== healthT'(expHealth)) begin
			$display("FAILED at %0t ns: pixHealth expected %0d got %0d", $time, expHealth,
				pixHealth);
			ok = 1'b0;
		end
		if (hitDone !== 1'b0) begin
			$display("FAILED at %0t ns: hitDone expected 0 got %0d", $time, hitDone);
			ok = 1'b0;
		end
	endtask

	// outputs follow the pixel one rising edge later, sampled at the next falling edge
	task automatic checkPixel(input integer x, input integer y, input integer expOn,
		input integer expHealth, output logic ok);
		ok = 1'b1;
		pixX = coordT'(x);
		pixY = coordT'(y);
		@(posedge clk);
		@(negedge clk);
		if (pixOn !== 1'(expOn)) begin
			$display("FAILED at %0t ns: pixOn expected %0d got %0d", $time, expOn, pixOn);
			ok = 1'b0;
		end
		if (pixHealth !== healthT'(expHealth)) begin
			$display("FAILED at %0t ns: pixHealth expected %0d got %0d", $time, expHealth,
				pixHealth);
			ok = 1'b0;
		end
	endtask

	task automatic checkHit(input integer x, input integer y, input integer expHit,
		input integer expId, output logic ok);
		integer waitCycles;
		ok = 1'b1;
		bulletX = coordT'(x);
		bulletY = coordT'(y);
		hitStrobe = 1'b1;
		@(negedge clk);
		hitStrobe = 1'b0;
		waitCycles = 0;
		while (!hitDone && waitCycles < 20) begin
			@(negedge clk);
			waitCycles = waitCycles + 1;
		end
		if (!hitDone) begin
			$display("timed out after 20 cycles waiting for hitDone for the bullet at (%0d,%0d)",
				x, y);
			abortRun = 1'b1;
			ok = 1'b0;
		end else begin
			// hitDone belongs to the cycle right after the strobe edge
			if (waitCycles != 0) begin
				$display("FAILED at %0t ns: hitDone latency expected 1 got %0d", $time,
					waitCycles + 1);
				ok = 1'b0;
			end
			if (hitBarrier !== 1'(expHit)) begin
				$display("FAILED at %0t ns: hitBarrier expected %0d got %0d", $time, expHit,
					hitBarrier);
				ok = 1'b0;
			end
			if (hitId !== barrierIdT'(expId)) begin
				$display("FAILED at %0t ns: hitId expected %0d got %0d", $time, expId, hitId);
				ok = 1'b0;
			end
			@(negedge clk);
			if (hitDone !== 1'b0) begin
				$display("hitDone stayed high for more than one cycle at %0t ns", $time);
				ok = 1'b0;
			end
			@(negedge clk);
		end
	endtask

	initial begin
		rstN = 1'b0;
		hitStrobe = 1'b0;
		pixX = '0;
		pixY = '0;
		bulletX = '0;
		bulletY = '0;
		passCount = 0;
		failCount = 0;
		testNum = 0;
		abortRun = 1'b0;
		fileDone = 1'b0;
		testOk = 1'b1;
		opName = "";

		applyReset(0, 0);

		fd = $fopen("barrierTrace.txt", "r");
		if (fd == 0) begin
			$display("could not open barrierTrace.txt for reading");
			abortRun = 1'b1;
		end

		while (fd != 0 && !fileDone && !abortRun) begin
			scanCode = $fscanf(fd, " %c", opChar);
			if (scanCode != 1) begin
				fileDone = 1'b1;
			end else if (opChar == "#") begin
				// skip the rest of a comment line
				scanCode = $fgets(restOfLine, fd);
			end else begin
				scanCode = $fscanf(fd, "%d %d %d %d", argX, argY, expA, expB);
				testNum = testNum + 1;
				testOk = 1'b1;
				if (scanCode != 4) begin
					$display("trace line for test %0d is missing values", testNum);
					abortRun = 1'b1;
				end else if (opChar == "P") begin
					opName = "pixel";
					checkPixel(argX, argY, expA, expB, testOk);
				end else if (opChar == "H") begin
					opName = "hit";
					checkHit(argX, argY, expA, expB, testOk);
				end else if (opChar == "R") begin
					opName = "reset";
					checkAfterReset(argX, argY, expA, expB, testOk);
				end else begin
					$display("trace has an unknown operation in test %0d", testNum);
					abortRun = 1'b1;
				end
				if (!abortRun || !testOk) begin
					if (testOk) begin
						passCount = passCount + 1;
						$display("test %0d %s (%0d,%0d) pass", testNum, opName, argX, argY);
					end else begin
						failCount = failCount + 1;
						$display("test %0d %s (%0d,%0d) fail", testNum, opName, argX, argY);
					end
				end
			end
		end

		if (fd != 0) begin
			$fclose(fd);
		end
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0 && !abortRun && passCount > 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- barrierTrace.txt
# columns: op x y expA expB, decimal
# P expects pixOn pixHealth, H expects hitBarrier hitId, R holds x y through reset
# locator edges after reset
P 80 400 1 3
P 111 431 1 3
P 112 400 0 0
P 224 400 1 3
P 255 431 1 3
P 256 400 0 0
P 368 400 1 3
P 399 431 1 3
P 400 400 0 0
P 512 400 1 3
P 543 431 1 3
P 544 400 0 0
P 80 399 0 0
P 80 432 0 0
# wear down bunker 1 column 1 row 2
H 235 418 1 1
P 232 416 1 2
H 239 423 1 1
P 236 420 1 1
H 232 416 1 1
P 235 419 0 0
# the block is gone now
H 233 417 0 1
# misses between bunkers and above the band
H 150 410 0 0
H 90 380 0 0
P 80 400 1 3
P 100 415 1 3
P 150 410 0 0
# neighbours of the dead block and the same block in other bunkers
P 228 418 1 3
P 242 418 1 3
P 235 410 1 3
P 235 426 1 3
P 92 418 1 3
P 380 418 1 3
P 524 418 1 3
H 520 400 1 3
P 520 400 1 2
# second reset restores every block
R 235 419 0 0
P 235 419 1 3
P 520 400 1 3

//--- sources.f
barrierPkg.sv
barrierLocate.sv
barrierHealthRegs.sv
barrierHitCtrl.sv
barrierPixel.sv
barrierTop.sv
tb_barrierTop.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_barrierTop -f sources.f

simOut=$(./obj_dir/Vtb_barrierTop)
echo "$simOut"

if echo "$simOut" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
